// File: logic/dual_issue_pkg.sv
package dual_issue_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int REG_ADDR_W = 5;                // Register index bits
    localparam int RF_DEPTH   = 1 << REG_ADDR_W;  // Architectural registers
    localparam int XLEN       = 32;               // Data word
    localparam int IMM_W      = 16;               // Immediate field

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [REG_ADDR_W-1:0] reg_idx_t;   // Register index
    typedef logic [XLEN-1:0]       xdata_t;     // Register file word
    typedef logic [IMM_W-1:0]      imm_t;       // Raw immediate from the slot

    // ALU operations
    // ADDI and LUI take the immediate in place of rs2
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLT  = 3'd5,   // Signed compare
        OP_ADDI = 3'd6,   // rs1 + sign-extended imm
        OP_LUI  = 3'd7    // imm in upper half
    } alu_op_e;

    // Issue FSM states
    typedef enum logic {
        IS_PAIR   = 1'b0,   // Accepting pairs
        IS_HOLD_B = 1'b1    // Replaying held slot b
    } issue_state_e;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import dual_issue_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // Read ports, two per lane
    input  reg_idx_t raddr_a1,
    input  reg_idx_t raddr_a2,
    input  reg_idx_t raddr_b1,
    input  reg_idx_t raddr_b2,
    output xdata_t   rdata_a1,
    output xdata_t   rdata_a2,
    output xdata_t   rdata_b1,
    output xdata_t   rdata_b2,

    // Write ports, one per lane
    input  logic     we_a,
    input  logic     we_b,
    input  reg_idx_t waddr_a,
    input  reg_idx_t waddr_b,
    input  xdata_t   wdata_a,
    input  xdata_t   wdata_b
);

    xdata_t rf [RF_DEPTH];   // Storage array
    logic   a_shadowed;      // Lane a write loses to lane b

    // Read with same-cycle write forwarding
    // Lane b checked first so the younger result wins
    function automatic xdata_t read_bypass(
        input reg_idx_t raddr,
        input xdata_t   stored
    );
        xdata_t rval;
        if (we_b && (raddr == waddr_b)) begin
            rval = wdata_b;
        end else if (we_a && (raddr == waddr_a)) begin
            rval = wdata_a;
        end else begin
            rval = stored;
        end
        return rval;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Combinational reads
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rdata_a1 = read_bypass(raddr_a1, rf[raddr_a1]);
        rdata_a2 = read_bypass(raddr_a2, rf[raddr_a2]);
        rdata_b1 = read_bypass(raddr_b1, rf[raddr_b1]);
        rdata_b2 = read_bypass(raddr_b2, rf[raddr_b2]);
    end

    //////////////////////////////////////////////////////////////////////
    // Synchronous writes
    //////////////////////////////////////////////////////////////////////

    assign a_shadowed = we_b && (waddr_a == waddr_b);   // WAW inside one cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                rf[i] <= '0;   // All registers read zero after reset
            end
        end else begin
            if (we_a && !a_shadowed) begin
                rf[waddr_a] <= wdata_a;
            end
            if (we_b) begin
                rf[waddr_b] <= wdata_b;   // Always lands
            end
        end
    end

endmodule

// File: logic/pair_issue.sv
`timescale 1ns/1ps

module pair_issue import dual_issue_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // Incoming pair
    input  logic     in_valid,
    input  logic     in_en_b,     // Slot b present
    input  alu_op_e  in_op_a,
    input  reg_idx_t in_rd_a,
    input  reg_idx_t in_rs1_a,
    input  reg_idx_t in_rs2_a,
    input  imm_t     in_imm_a,
    input  alu_op_e  in_op_b,
    input  reg_idx_t in_rd_b,
    input  reg_idx_t in_rs1_b,
    input  reg_idx_t in_rs2_b,
    input  imm_t     in_imm_b,
    output logic     in_ready,

    // Issue to lane a
    output logic     iss_valid_a,
    output alu_op_e  iss_op_a,
    output reg_idx_t iss_rd_a,
    output reg_idx_t iss_rs1_a,
    output reg_idx_t iss_rs2_a,
    output imm_t     iss_imm_a,

    // Issue to lane b
    output logic     iss_valid_b,
    output alu_op_e  iss_op_b,
    output reg_idx_t iss_rd_b,
    output reg_idx_t iss_rs1_b,
    output reg_idx_t iss_rs2_b,
    output imm_t     iss_imm_b
);

    issue_state_e state;
    issue_state_e state_nxt;

    // Held copy of slot b for a split pair
    alu_op_e  hold_op_b;
    reg_idx_t hold_rd_b;
    reg_idx_t hold_rs1_b;
    reg_idx_t hold_rs2_b;
    imm_t     hold_imm_b;

    logic b_uses_rs2;   // ADDI and LUI ignore rs2
    logic dep;          // Slot b reads slot a's destination
    logic accept;
    logic split;

    assign b_uses_rs2 = (in_op_b != OP_ADDI) && (in_op_b != OP_LUI);
    assign dep = in_en_b && ((in_rs1_b == in_rd_a) ||
                             (b_uses_rs2 && (in_rs2_b == in_rd_a)));

    assign in_ready = (state == IS_PAIR);   // Low only while replaying b
    assign accept   = in_valid && in_ready && !rst;   // No issue while in reset
    assign split    = accept && dep;

    // Lane a always comes straight from slot a
    assign iss_valid_a = accept;
    assign iss_op_a    = in_op_a;
    assign iss_rd_a    = in_rd_a;
    assign iss_rs1_a   = in_rs1_a;
    assign iss_rs2_a   = in_rs2_a;
    assign iss_imm_a   = in_imm_a;

    // Lane b from input or hold register
    always_comb begin
        if (state == IS_HOLD_B) begin
            iss_valid_b = 1'b1;
            iss_op_b    = hold_op_b;
            iss_rd_b    = hold_rd_b;
            iss_rs1_b   = hold_rs1_b;   // Picks up lane a result via bypass
            iss_rs2_b   = hold_rs2_b;
            iss_imm_b   = hold_imm_b;
        end else begin
            iss_valid_b = accept && in_en_b && !dep;   // Dual issue
            iss_op_b    = in_op_b;
            iss_rd_b    = in_rd_b;
            iss_rs1_b   = in_rs1_b;
            iss_rs2_b   = in_rs2_b;
            iss_imm_b   = in_imm_b;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            IS_PAIR:   state_nxt = split ? IS_HOLD_B : IS_PAIR;
            IS_HOLD_B: state_nxt = IS_PAIR;   // One cycle of replay
            default:   state_nxt = IS_PAIR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IS_PAIR;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (split) begin   // Capture at the accepting edge
            hold_op_b  <= in_op_b;
            hold_rd_b  <= in_rd_b;
            hold_rs1_b <= in_rs1_b;
            hold_rs2_b <= in_rs2_b;
            hold_imm_b <= in_imm_b;
        end
    end

endmodule

// File: logic/alu_lane.sv
`timescale 1ns/1ps

module alu_lane import dual_issue_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // Issue side
    input  logic     iss_valid,
    input  alu_op_e  iss_op,
    input  reg_idx_t iss_rd,
    input  imm_t     iss_imm,
    input  xdata_t   opnd1,     // rs1 value from the register file
    input  xdata_t   opnd2,     // rs2 value from the register file

    // Writeback stage
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output xdata_t   wb_data
);

    xdata_t imm_sext;     // Sign-extended for ADDI
    xdata_t imm_upper;    // Shifted into the high half for LUI
    xdata_t sum;          // Shared adder for ADD and ADDI
    xdata_t add_rhs;
    logic   slt_bit;
    xdata_t alu_result;

    //////////////////////////////////////////////////////////////////////
    // Immediate and operand prep
    //////////////////////////////////////////////////////////////////////

    assign imm_sext  = {{(XLEN-IMM_W){iss_imm[IMM_W-1]}}, iss_imm};
    assign imm_upper = {iss_imm, {(XLEN-IMM_W){1'b0}}};

    assign add_rhs = (iss_op == OP_ADDI) ? imm_sext : opnd2;
    assign sum     = opnd1 + add_rhs;

    // Two's complement compare
    assign slt_bit = $signed(opnd1) < $signed(opnd2);

    //////////////////////////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (iss_op)
            OP_ADD:  alu_result = sum;
            OP_ADDI: alu_result = sum;
            OP_SUB:  alu_result = opnd1 - opnd2;
            OP_AND:  alu_result = opnd1 & opnd2;
            OP_OR:   alu_result = opnd1 | opnd2;
            OP_XOR:  alu_result = opnd1 ^ opnd2;
            OP_SLT:  alu_result = {{(XLEN-1){1'b0}}, slt_bit};   // 0 or 1
            OP_LUI:  alu_result = imm_upper;                       // rs1 unused
            default: alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Writeback register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= iss_valid;   // One cycle after issue
        end
    end

    // Result and destination hold while the lane idles
    always_ff @(posedge clk) begin
        if (iss_valid) begin
            wb_rd   <= iss_rd;
            wb_data <= alu_result;
        end
    end

endmodule

// File: logic/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core import dual_issue_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    // Instruction pair
    input  logic     in_valid,
    input  logic     in_en_b,
    input  alu_op_e  in_op_a,
    input  reg_idx_t in_rd_a,
    input  reg_idx_t in_rs1_a,
    input  reg_idx_t in_rs2_a,
    input  imm_t     in_imm_a,
    input  alu_op_e  in_op_b,
    input  reg_idx_t in_rd_b,
    input  reg_idx_t in_rs1_b,
    input  reg_idx_t in_rs2_b,
    input  imm_t     in_imm_b,
    output logic     in_ready,

    // Writeback
    output logic     wb_valid_a,
    output reg_idx_t wb_rd_a,
    output xdata_t   wb_data_a,
    output logic     wb_valid_b,
    output reg_idx_t wb_rd_b,
    output xdata_t   wb_data_b
);

    logic     iss_valid_a, iss_valid_b;
    alu_op_e  iss_op_a, iss_op_b;
    reg_idx_t iss_rd_a, iss_rd_b;
    reg_idx_t iss_rs1_a, iss_rs1_b;
    reg_idx_t iss_rs2_a, iss_rs2_b;
    imm_t     iss_imm_a, iss_imm_b;
    xdata_t   rdata_a1, rdata_a2, rdata_b1, rdata_b2;   // Lane operands

    //////////////////////////////////////////////////////////////////////
    // Issue
    //////////////////////////////////////////////////////////////////////

    pair_issue u_issue (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_en_b     (in_en_b),
        .in_op_a     (in_op_a),
        .in_rd_a     (in_rd_a),
        .in_rs1_a    (in_rs1_a),
        .in_rs2_a    (in_rs2_a),
        .in_imm_a    (in_imm_a),
        .in_op_b     (in_op_b),
        .in_rd_b     (in_rd_b),
        .in_rs1_b    (in_rs1_b),
        .in_rs2_b    (in_rs2_b),
        .in_imm_b    (in_imm_b),
        .in_ready    (in_ready),
        .iss_valid_a (iss_valid_a),
        .iss_op_a    (iss_op_a),
        .iss_rd_a    (iss_rd_a),
        .iss_rs1_a   (iss_rs1_a),
        .iss_rs2_a   (iss_rs2_a),
        .iss_imm_a   (iss_imm_a),
        .iss_valid_b (iss_valid_b),
        .iss_op_b    (iss_op_b),
        .iss_rd_b    (iss_rd_b),
        .iss_rs1_b   (iss_rs1_b),
        .iss_rs2_b   (iss_rs2_b),
        .iss_imm_b   (iss_imm_b)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute lanes
    //////////////////////////////////////////////////////////////////////

    alu_lane u_lane_a (
        .clk       (clk),
        .rst       (rst),
        .iss_valid (iss_valid_a),
        .iss_op    (iss_op_a),
        .iss_rd    (iss_rd_a),
        .iss_imm   (iss_imm_a),
        .opnd1     (rdata_a1),
        .opnd2     (rdata_a2),
        .wb_valid  (wb_valid_a),
        .wb_rd     (wb_rd_a),
        .wb_data   (wb_data_a)
    );

    alu_lane u_lane_b (
        .clk       (clk),
        .rst       (rst),
        .iss_valid (iss_valid_b),
        .iss_op    (iss_op_b),
        .iss_rd    (iss_rd_b),
        .iss_imm   (iss_imm_b),
        .opnd1     (rdata_b1),
        .opnd2     (rdata_b2),
        .wb_valid  (wb_valid_b),
        .wb_rd     (wb_rd_b),
        .wb_data   (wb_data_b)
    );

    // Shared file, written back from both lanes
    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .raddr_a1 (iss_rs1_a),
        .raddr_a2 (iss_rs2_a),
        .raddr_b1 (iss_rs1_b),
        .raddr_b2 (iss_rs2_b),
        .rdata_a1 (rdata_a1),
        .rdata_a2 (rdata_a2),
        .rdata_b1 (rdata_b1),
        .rdata_b2 (rdata_b2),
        .we_a     (wb_valid_a),
        .we_b     (wb_valid_b),
        .waddr_a  (wb_rd_a),
        .waddr_b  (wb_rd_b),
        .wdata_a  (wb_data_a),
        .wdata_b  (wb_data_b)
    );

endmodule

// File: verification/dual_issue_asserts.sv
`timescale 1ns/1ps

module dual_issue_asserts import dual_issue_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         in_ready,
    input logic         iss_valid_a,
    input logic         iss_valid_b,
    input issue_state_e state
);

    int fail_count = 0;   // Read by the testbench at the end

    // Replay of slot b takes a single cycle
    ready_low_one_cycle: assert property (@(posedge clk) disable iff (rst)
        !in_ready |=> in_ready)
    else begin
        $error("in_ready low for two cycles in a row");
        fail_count++;
    end

    // Held slot b goes out on lane b, lane a idle
    hold_issues_b: assert property (@(posedge clk) disable iff (rst)
        (state == IS_HOLD_B) |-> (iss_valid_b && !iss_valid_a))
    else begin
        $error("IS_HOLD_B without lane b issue");
        fail_count++;
    end

    no_issue_in_reset: assert property (@(posedge clk)
        rst |-> !(iss_valid_a || iss_valid_b))
    else begin
        $error("Issue strobe high during reset");
        fail_count++;
    end

endmodule

bind pair_issue dual_issue_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .in_ready    (in_ready),
    .iss_valid_a (iss_valid_a),
    .iss_valid_b (iss_valid_b),
    .state       (state)
);

// File: verification/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue import dual_issue_pkg::*; ();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_PAIRS       = 600;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_PAIRS * 3 + 200;

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_en_b;
    alu_op_e  in_op_a;
    alu_op_e  in_op_b;
    reg_idx_t in_rd_a;
    reg_idx_t in_rs1_a;
    reg_idx_t in_rs2_a;
    reg_idx_t in_rd_b;
    reg_idx_t in_rs1_b;
    reg_idx_t in_rs2_b;
    imm_t     in_imm_a;
    imm_t     in_imm_b;
    logic     in_ready;
    logic     wb_valid_a;
    logic     wb_valid_b;
    reg_idx_t wb_rd_a;
    reg_idx_t wb_rd_b;
    xdata_t   wb_data_a;
    xdata_t   wb_data_b;

    logic [31:0] lfsr = 32'd98;   // Galois LFSR state
    xdata_t      model_rf [RF_DEPTH];   // Architectural state of the model
    reg_idx_t    exp_rd_a[$];
    reg_idx_t    exp_rd_b[$];
    xdata_t      exp_data_a[$];
    xdata_t      exp_data_b[$];
    logic        hold_pending = 1'b0;   // Split pair, slot b due next cycle
    logic        exp_wbv_a = 1'b0;
    logic        exp_wbv_b = 1'b0;
    logic        took = 1'b0;           // Pair accepted at the last edge
    int          pairs_done = 0;
    int          errors = 0;

    dual_issue_core i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_en_b    (in_en_b),
        .in_op_a    (in_op_a),
        .in_rd_a    (in_rd_a),
        .in_rs1_a   (in_rs1_a),
        .in_rs2_a   (in_rs2_a),
        .in_imm_a   (in_imm_a),
        .in_op_b    (in_op_b),
        .in_rd_b    (in_rd_b),
        .in_rs1_b   (in_rs1_b),
        .in_rs2_b   (in_rs2_b),
        .in_imm_b   (in_imm_b),
        .in_ready   (in_ready),
        .wb_valid_a (wb_valid_a),
        .wb_rd_a    (wb_rd_a),
        .wb_data_a  (wb_data_a),
        .wb_valid_b (wb_valid_b),
        .wb_rd_b    (wb_rd_b),
        .wb_data_b  (wb_data_b)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;   // Taps 32 22 2 1
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};   // One step per bit
        end
        return v;
    endfunction

    // Indices from 3 bits so hazards come up often
    task automatic rand_slot(output alu_op_e op, output reg_idx_t rd, output reg_idx_t rs1,
                             output reg_idx_t rs2, output imm_t imm);
        op  = alu_op_e'(3'(rand_bits(3)));
        rd  = reg_idx_t'(rand_bits(3));
        rs1 = reg_idx_t'(rand_bits(3));
        rs2 = reg_idx_t'(rand_bits(3));
        imm = imm_t'(rand_bits(16));
    endtask

    task automatic new_pair();
        in_valid = (rand_bits(2) != 32'd0);   // Idle about one cycle in four
        in_en_b  = (rand_bits(3) != 32'd0);
        rand_slot(in_op_a, in_rd_a, in_rs1_a, in_rs2_a, in_imm_a);
        rand_slot(in_op_b, in_rd_b, in_rs1_b, in_rs2_b, in_imm_b);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    function automatic logic reads_rs2(input alu_op_e op);
        return (op != OP_ADDI) && (op != OP_LUI);
    endfunction

    function automatic xdata_t model_alu(input alu_op_e op, input xdata_t s1, input xdata_t s2,
                                         input imm_t imm);
        xdata_t res;
        case (op)
            OP_ADD:  res = s1 + s2;
            OP_SUB:  res = s1 - s2;
            OP_AND:  res = s1 & s2;
            OP_OR:   res = s1 | s2;
            OP_XOR:  res = s1 ^ s2;
            OP_SLT:  res = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
            OP_ADDI: res = s1 + {{16{imm[15]}}, imm};
            default: res = {imm, 16'h0000};   // LUI
        endcase
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Runs mid-cycle, where DUT outputs and TB inputs are settled
    task automatic monitor_cycle();
        logic   accept;
        logic   dep;
        xdata_t res;
        check_value("in_ready", 32'(in_ready), 32'(!hold_pending));
        check_value("wb_valid_a", 32'(wb_valid_a), 32'(exp_wbv_a));
        check_value("wb_valid_b", 32'(wb_valid_b), 32'(exp_wbv_b));
        if (wb_valid_a && (exp_rd_a.size() == 0)) begin
            errors++;
            $display("Lane a wrote back with no instruction outstanding at %0t", $time);
        end else if (wb_valid_a) begin
            check_value("wb_rd_a", 32'(wb_rd_a), 32'(exp_rd_a.pop_front()));
            check_value("wb_data_a", wb_data_a, exp_data_a.pop_front());
        end
        if (wb_valid_b && (exp_rd_b.size() == 0)) begin
            errors++;
            $display("Lane b wrote back with no instruction outstanding at %0t", $time);
        end else if (wb_valid_b) begin
            check_value("wb_rd_b", 32'(wb_rd_b), 32'(exp_rd_b.pop_front()));
            check_value("wb_data_b", wb_data_b, exp_data_b.pop_front());
        end

        accept = in_valid && !hold_pending;   // Taken at the coming edge
        dep = accept && in_en_b && ((in_rs1_b == in_rd_a) ||
                                    (reads_rs2(in_op_b) && (in_rs2_b == in_rd_a)));
        if (accept) begin
            res = model_alu(in_op_a, model_rf[in_rs1_a], model_rf[in_rs2_a], in_imm_a);
            model_rf[in_rd_a] = res;
            exp_rd_a.push_back(in_rd_a);
            exp_data_a.push_back(res);
            if (in_en_b) begin   // Program order, so b overwrites a on equal rd
                res = model_alu(in_op_b, model_rf[in_rs1_b], model_rf[in_rs2_b], in_imm_b);
                model_rf[in_rd_b] = res;
                exp_rd_b.push_back(in_rd_b);
                exp_data_b.push_back(res);
            end
            pairs_done++;
        end
        exp_wbv_a    = accept;
        exp_wbv_b    = hold_pending || (accept && in_en_b && !dep);
        hold_pending = dep;
        took         = accept;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Processes
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                monitor_cycle();
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d clock cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b1;   // Offered during reset, must not issue
        in_en_b  = 1'b1;
        in_op_a  = OP_ADD;
        in_op_b  = OP_ADD;
        in_rd_a  = '0;
        in_rs1_a = '0;
        in_rs2_a = '0;
        in_rd_b  = '0;
        in_rs1_b = '0;
        in_rs2_b = '0;
        in_imm_a = '0;
        in_imm_b = '0;
        for (int i = 0; i < RF_DEPTH; i++) begin
            model_rf[i] = '0;   // Matches the cleared file
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        new_pair();
        while (pairs_done < NUM_PAIRS) begin
            @(posedge clk);
            #1;
            if (took || !in_valid) begin   // Pair held until taken
                new_pair();
            end
        end
        in_valid = 1'b0;
        while ((exp_rd_a.size() != 0) || (exp_rd_b.size() != 0)) begin
            @(posedge clk);   // Drain the writeback stage
        end
        repeat (4) @(posedge clk);
        errors += i_dut.u_issue.u_asserts.fail_count;
        $display("Pairs accepted %0d, errors %0d", pairs_done, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/dual_issue_pkg.sv
logic/reg_file.sv
logic/pair_issue.sv
logic/alu_lane.sv
logic/dual_issue_core.sv
verification/dual_issue_asserts.sv
verification/tb_dual_issue.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dual_issue -f filelist.f \
    --Mdir obj_dir -o sim_dual_issue

# Error limit raised so the testbench reaches its own verdict
out=$(./obj_dir/sim_dual_issue +verilator+error+limit+1000 2>&1)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
